/* build.f */
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/control_fsm.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/barrel_shifter.sv
hw/execute_unit.sv
hw/cpu_top.sv
verification/cpu_properties.sv
verification/cpu_tb.sv

/* hw/barrel_shifter.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module barrel_shifter import cpu_isa_pkg::*; (
    input  word_t      value,
    input  logic [3:0] amount,
    input  shift_fn_e  fn,
    output word_t      result
);

    word_t s_in;
    word_t s8;
    word_t s4;
    word_t s2;
    word_t s1;
    logic  left;
    logic  fill;

    function automatic word_t reverse(input word_t w);
        word_t r;
        for (int i = 0; i < `CPU_XLEN; i++) begin
            r[i] = w[`CPU_XLEN-1-i];
        end
        return r;
    endfunction

    assign left = !fn[1];  // 00 and 01 both shift left
    assign fill = (fn == SH_ASR) ? value[`CPU_XLEN-1] : 1'b0;
    assign s_in = left ? reverse(value) : value;

    assign s8 = amount[3] ? {{8{fill}}, s_in[`CPU_XLEN-1:8]} : s_in;
    assign s4 = amount[2] ? {{4{fill}}, s8[`CPU_XLEN-1:4]} : s8;
    assign s2 = amount[1] ? {{2{fill}}, s4[`CPU_XLEN-1:2]} : s4;
    assign s1 = amount[0] ? {fill, s2[`CPU_XLEN-1:1]} : s2;

    assign result = left ? reverse(s1) : s1;

endmodule

/* hw/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = FETCH;
        case (state)
            FETCH: begin
                case (opcode)
                    OP_NOP1, OP_NOP2: state_nxt = NOP_RET;
                    OP_JUMP: state_nxt = JUMP;
                    OP_BEQ, OP_BNE, OP_ADD, OP_NAND, OP_SUB, OP_OR: state_nxt = DECODE_R;
                    default: state_nxt = DECODE_I;  // Shift and immediates
                endcase
            end
            DECODE_R: state_nxt = (opcode == OP_BEQ || opcode == OP_BNE) ? BRANCH : EXEC_R;
            DECODE_I: state_nxt = (opcode == OP_SHIFT) ? EXEC_SHIFT : EXEC_I;
            EXEC_R, EXEC_I, EXEC_SHIFT: state_nxt = WRITEBACK;
            default: state_nxt = FETCH;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            FETCH: begin
                ctrl.pc_wr   = 1'b1;  // pc + step through the ALU
                ctrl.ir_load = 1'b1;
            end
            DECODE_R: ctrl.read_c = 1'b1;  // Branch target
            DECODE_I: ctrl.rs_is_rd = 1'b1;
            EXEC_R: begin
                ctrl.src_a_reg = 1'b1;
                ctrl.src_b     = SRC_B_REG;
                case (opcode)
                    OP_SUB:  ctrl.alu_op = ALU_SUB;
                    OP_NAND: ctrl.alu_op = ALU_NAND;
                    OP_OR:   ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            EXEC_I: begin
                ctrl.src_a_reg = 1'b1;
                ctrl.src_b     = (opcode == OP_ADDUI || opcode == OP_SUBUI) ?
                                 SRC_B_ZEXT8 : SRC_B_SEXT8;
                case (opcode)
                    OP_SUBI, OP_SUBUI: ctrl.alu_op = ALU_SUB;
                    OP_NANDI:          ctrl.alu_op = ALU_NAND;
                    OP_ORI:            ctrl.alu_op = ALU_OR;
                    default:           ctrl.alu_op = ALU_ADD;
                endcase
            end
            EXEC_SHIFT: ctrl.use_shift = 1'b1;
            BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.src_a_reg = 1'b1;
                ctrl.src_b     = SRC_B_REG;
                ctrl.alu_op    = ALU_SUB;  // Compare for zero flag
            end
            JUMP: begin
                ctrl.pc_wr = 1'b1;
                ctrl.src_b = SRC_B_ZEXT12;
            end
            WRITEBACK: ctrl.reg_wr = 1'b1;
            default: ;
        endcase
    end

endmodule

/* hw/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    import cpu_isa_pkg::*;

    // One-hot with the top bit spare
    typedef enum logic [10:0] {
        FETCH      = 11'b000_0000_0001,
        DECODE_R   = 11'b000_0000_0010,
        DECODE_I   = 11'b000_0000_0100,
        EXEC_R     = 11'b000_0000_1000,
        EXEC_I     = 11'b000_0001_0000,
        EXEC_SHIFT = 11'b000_0010_0000,
        BRANCH     = 11'b000_0100_0000,
        JUMP       = 11'b000_1000_0000,
        WRITEBACK  = 11'b001_0000_0000,
        NOP_RET    = 11'b010_0000_0000
    } state_e;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_SUB  = 2'b01,
        ALU_NAND = 2'b10,
        ALU_OR   = 2'b11
    } alu_op_e;

    typedef enum logic [2:0] {
        SRC_B_STEP   = 3'd0,
        SRC_B_REG    = 3'd1,
        SRC_B_SEXT8  = 3'd2,
        SRC_B_ZEXT8  = 3'd3,
        SRC_B_ZEXT12 = 3'd4
    } src_b_e;

    typedef struct packed {
        logic    pc_wr;      // Unconditional PC update
        logic    branch;
        logic    src_a_reg;  // 0 selects PC
        src_b_e  src_b;
        alu_op_e alu_op;
        logic    use_shift;
        logic    rs_is_rd;   // First read port takes ir[11:8]
        logic    read_c;
        logic    reg_wr;
        logic    ir_load;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

/* hw/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and address width
`define CPU_XLEN 16

// Architectural registers with r0 hardwired to zero
`define CPU_NREGS 16

`define CPU_RESET_PC 0

// Byte increment per fetched instruction
`define CPU_PC_STEP 2

`endif

/* hw/cpu_isa_pkg.sv */
`include "cpu_defs.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;

    typedef logic [3:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_SHIFT = 4'd0,
        OP_NOP1  = 4'd1,  // Former load
        OP_NOP2  = 4'd2,  // Former store
        OP_JUMP  = 4'd3,
        OP_BEQ   = 4'd4,
        OP_BNE   = 4'd5,
        OP_ORI   = 4'd6,
        OP_NANDI = 4'd7,
        OP_ADD   = 4'd8,
        OP_ADDI  = 4'd9,
        OP_ADDUI = 4'd10,
        OP_NAND  = 4'd11,
        OP_SUB   = 4'd12,
        OP_SUBI  = 4'd13,
        OP_SUBUI = 4'd14,
        OP_OR    = 4'd15
    } opcode_e;

    // imm8 is {rs, rt}, imm12 is {rd, rs, rt}, shift amount is rs
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
    } instr_t;

    typedef enum logic [1:0] {
        SH_LSL     = 2'b00,
        SH_LSL_ALT = 2'b01,
        SH_LSR     = 2'b10,
        SH_ASR     = 2'b11
    } shift_fn_e;

endpackage

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  instr_t instr,
    output word_t  pc,
    output wb_t    wb
);

    ctrl_t  ctrl;
    instr_t ir;
    word_t  a;
    word_t  b;
    word_t  c;
    logic   pc_load;
    word_t  pc_next;

    control_fsm i_control_fsm (
        .clk    (clk),
        .rst    (rst),
        .opcode (ir.opcode),
        .ctrl   (ctrl)
    );

    fetch_unit i_fetch_unit (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .ctrl    (ctrl),
        .pc_load (pc_load),
        .pc_next (pc_next),
        .pc      (pc),
        .ir      (ir)
    );

    reg_file i_reg_file (
        .clk  (clk),
        .ir   (ir),
        .ctrl (ctrl),
        .wb   (wb),
        .a    (a),
        .b    (b),
        .c    (c)
    );

    execute_unit i_execute_unit (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .ir      (ir),
        .pc      (pc),
        .a       (a),
        .b       (b),
        .c       (c),
        .pc_load (pc_load),
        .pc_next (pc_next),
        .wb      (wb)
    );

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  ctrl_t  ctrl,
    input  instr_t ir,
    input  word_t  pc,
    input  word_t  a,
    input  word_t  b,
    input  word_t  c,
    output logic   pc_load,
    output word_t  pc_next,
    output wb_t    wb
);

    word_t op_a;
    word_t op_b;
    word_t alu_res;
    word_t shift_res;
    word_t alu_out;
    logic  zf;

    assign op_a = ctrl.src_a_reg ? a : pc;

    always_comb begin
        case (ctrl.src_b)
            SRC_B_STEP:   op_b = word_t'(`CPU_PC_STEP);
            SRC_B_REG:    op_b = b;
            SRC_B_SEXT8:  op_b = {{8{ir.rs[3]}}, ir.rs, ir.rt};
            SRC_B_ZEXT8:  op_b = {8'h00, ir.rs, ir.rt};
            SRC_B_ZEXT12: op_b = {4'h0, ir.rd, ir.rs, ir.rt};
            default:      op_b = '0;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_NAND: alu_res = ~(op_a & op_b);
            default:  alu_res = op_a | op_b;
        endcase
    end

    assign zf = (alu_res == '0);

    barrel_shifter i_barrel_shifter (
        .value  (a),
        .amount (ir.rs),
        .fn     (shift_fn_e'(ir.rt[1:0])),
        .result (shift_res)
    );

    // Opcode bit 0 set means branch on not equal
    assign pc_load = ctrl.pc_wr | (ctrl.branch & (zf ^ ir.opcode[0]));
    assign pc_next = ctrl.branch ? c : alu_res;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alu_out <= '0;
        end else begin
            alu_out <= ctrl.use_shift ? shift_res : alu_res;
        end
    end

    assign wb.valid = ctrl.reg_wr;
    assign wb.addr  = ir.rd;
    assign wb.data  = alu_out;

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  instr_t instr,
    input  ctrl_t  ctrl,
    input  logic   pc_load,
    input  word_t  pc_next,
    output word_t  pc,
    output instr_t ir
);

    instr_t ir_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= word_t'(`CPU_RESET_PC);
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_load) begin
            ir_q <= instr;
        end
    end

    // Transparent while loading so the FSM can dispatch from FETCH
    assign ir = ctrl.ir_load ? instr : ir_q;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic   clk,
    input  instr_t ir,
    input  ctrl_t  ctrl,
    input  wb_t    wb,
    output word_t  a,
    output word_t  b,
    output word_t  c
);

    word_t     regs [`CPU_NREGS];
    reg_addr_t ra;

    function automatic word_t read_reg(input reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];  // r0 reads as zero
    endfunction

    assign ra = ctrl.rs_is_rd ? ir.rd : ir.rs;

    always_ff @(posedge clk) begin
        a <= read_reg(ra);
        b <= read_reg(ir.rt);
        if (ctrl.read_c) begin
            c <= read_reg(ir.rd);
        end
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Checks failed" sim.log || grep -q "%Error" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

/* verification/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input logic   clk,
    input logic   rst,
    input word_t  pc,
    input wb_t    wb,
    input state_e state
);

    wb_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        wb.valid |=> !wb.valid)
        else $error("wb.valid stayed high for two cycles");

    pc_even: assert property (@(posedge clk) disable iff (!rst)
        pc[0] == 1'b0)
        else $error("pc is odd");

    state_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot(state))
        else $error("control state is not one-hot");

    // First cycle out of reset is FETCH
    wb_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !wb.valid)
        else $error("wb.valid high right after reset");

endmodule

bind cpu_top cpu_properties i_cpu_properties (
    .clk   (clk),
    .rst   (rst),
    .pc    (pc),
    .wb    (wb),
    .state (i_control_fsm.state)
);

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_ROWS     = 96;
    localparam int MEM_WORDS    = 256;

    typedef enum logic [1:0] {CL_WRITE, CL_NONE, CL_SKIP} row_class_e;

    logic   clk;
    logic   rst;
    instr_t instr = '0;
    word_t  pc;
    wb_t    wb;

    logic [15:0] imem [MEM_WORDS];

    // Program table with expected results
    instr_t     row_instr  [MAX_ROWS];
    row_class_e row_class  [MAX_ROWS];
    reg_addr_t  row_addr   [MAX_ROWS];
    word_t      row_val    [MAX_ROWS];
    logic       row_taken  [MAX_ROWS];
    word_t      row_target [MAX_ROWS];

    reg_addr_t exp_addr_q [$];
    word_t     exp_val_q  [$];
    word_t     exp_pc_q   [$];

    word_t  model_regs [`CPU_NREGS];
    int     n_rows;
    int     skip_left;
    integer seed;
    int     errors = 0;
    int     n_wb = 0;
    int     cycle = 0;
    int     last_pc_change = 0;
    word_t  pc_prev = '0;
    logic   built = 1'b0;

    cpu_top i_cpu_top (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .pc    (pc),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic instr_t make_instr(input opcode_e op, input int rd, input int rs,
                                          input int rt);
        instr_t w;
        w.opcode = op;
        w.rd     = reg_addr_t'(rd);
        w.rs     = reg_addr_t'(rs);
        w.rt     = reg_addr_t'(rt);
        return w;
    endfunction

    function automatic instr_t make_imm(input opcode_e op, input int rd, input logic [7:0] imm);
        return make_instr(op, rd, int'(imm[7:4]), int'(imm[3:0]));
    endfunction

    function automatic logic [7:0] rand8();
        return 8'($random(seed));
    endfunction

    function automatic word_t shift_model(input word_t v, input int amt, input logic [1:0] fn);
        case (fn)
            2'b10:   return v >> amt;
            2'b11:   return word_t'($signed(v) >>> amt);
            default: return v << amt;  // 00 and 01
        endcase
    endfunction

    // Appends one row and runs it on the register model
    task automatic add_row(input instr_t ins);
        word_t rd_val;
        word_t a_val;
        word_t b_val;
        word_t imm_s;
        word_t imm_z;
        word_t res;
        word_t next_pc;
        word_t target;
        logic  writes;
        logic  taken;
        int    idx;
        idx = n_rows;
        n_rows++;
        row_instr[idx] = ins;
        row_taken[idx] = 1'b0;
        row_addr[idx]  = ins.rd;
        if (skip_left > 0) begin
            row_class[idx] = CL_SKIP;  // Never fetched
            skip_left--;
        end else begin
            rd_val  = model_regs[ins.rd];
            a_val   = model_regs[ins.rs];
            b_val   = model_regs[ins.rt];
            imm_z   = {8'h00, ins.rs, ins.rt};
            imm_s   = {{8{ins.rs[3]}}, ins.rs, ins.rt};
            next_pc = word_t'(2 * idx + `CPU_PC_STEP);
            writes  = 1'b1;
            taken   = 1'b0;
            res     = '0;
            target  = '0;
            case (ins.opcode)
                OP_ADD:   res = a_val + b_val;
                OP_SUB:   res = a_val - b_val;
                OP_NAND:  res = ~(a_val & b_val);
                OP_OR:    res = a_val | b_val;
                OP_ADDI:  res = rd_val + imm_s;
                OP_ADDUI: res = rd_val + imm_z;
                OP_SUBI:  res = rd_val - imm_s;
                OP_SUBUI: res = rd_val - imm_z;
                OP_NANDI: res = ~(rd_val & imm_s);
                OP_ORI:   res = rd_val | imm_s;
                OP_SHIFT: res = shift_model(rd_val, int'(ins.rs), ins.rt[1:0]);
                OP_BEQ, OP_BNE: begin
                    writes = 1'b0;
                    taken  = (ins.opcode == OP_BEQ) ? (a_val == b_val) : (a_val != b_val);
                    target = rd_val;
                end
                OP_JUMP: begin
                    writes = 1'b0;
                    taken  = 1'b1;
                    target = next_pc + {4'h0, ins.rd, ins.rs, ins.rt};
                end
                default: writes = 1'b0;
            endcase
            row_class[idx]  = writes ? CL_WRITE : CL_NONE;
            row_val[idx]    = res;
            row_taken[idx]  = taken;
            row_target[idx] = target;
            if (writes && ins.rd != '0) begin
                model_regs[ins.rd] = res;
            end
            if (taken) begin
                skip_left = int'(target - next_pc) / 2;
            end
        end
    endtask

    // Target in r10 lies past the poison rows
    task automatic branch_test(input opcode_e op, input int rs, input int rt, input int skip);
        int target;
        int p;
        target = 2 * (n_rows + 3 + skip);
        add_row(make_instr(OP_OR, 10, 0, 0));
        add_row(make_imm(OP_ADDUI, 10, 8'(target)));
        add_row(make_instr(op, 10, rs, rt));
        for (p = 0; p < skip; p++) begin
            add_row(make_imm(OP_NANDI, 12, 8'h00));  // Poison
        end
    endtask

    task automatic build_program();
        int r;
        int k;
        n_rows    = 0;
        skip_left = 0;
        seed      = 32'h65e3;
        for (r = 0; r < `CPU_NREGS; r++) begin
            model_regs[r] = '0;
        end
        for (r = 1; r <= 12; r++) begin
            add_row(make_instr(OP_OR, r, 0, 0));
        end
        for (k = 0; k < 2; k++) begin
            add_row(make_imm(OP_ADDI, 1, rand8()));
            add_row(make_imm(OP_ADDUI, 2, rand8()));
            add_row(make_imm(OP_SUBI, 3, rand8()));
            add_row(make_imm(OP_SUBUI, 4, rand8()));
            add_row(make_imm(OP_NANDI, 5, rand8()));
            add_row(make_imm(OP_ORI, 6, rand8()));
        end
        add_row(make_instr(OP_ADD, 7, 1, 2));
        add_row(make_instr(OP_SUB, 8, 3, 4));
        add_row(make_instr(OP_NAND, 9, 5, 6));
        add_row(make_instr(OP_OR, 7, 7, 8));
        add_row(make_instr(OP_ADD, 0, 1, 2));  // Discarded by r0
        add_row(make_instr(OP_ADD, 8, 0, 0));
        add_row(make_imm(OP_NANDI, 9, 8'h0f));  // Forces a negative value
        add_row(make_instr(OP_SHIFT, 9, 3, 3));
        add_row(make_instr(OP_SHIFT, 9, 8, 2));
        add_row(make_instr(OP_SHIFT, 1, 4, 0));
        add_row(make_instr(OP_SHIFT, 2, 1, 1));
        add_row(make_instr(OP_SHIFT, 3, 15, 2));
        add_row(make_instr(OP_SHIFT, 4, 7, 3));
        branch_test(OP_BEQ, 0, 0, 2);
        branch_test(OP_BEQ, 0, 10, 2);
        branch_test(OP_BNE, 0, 10, 2);
        branch_test(OP_BNE, 0, 0, 2);
        add_row(make_instr(OP_JUMP, 0, 0, 4));
        add_row(make_imm(OP_NANDI, 12, 8'h00));
        add_row(make_imm(OP_NANDI, 12, 8'h00));
        add_row(make_imm(OP_ADDI, 11, rand8()));
        add_row(make_instr(OP_NOP1, 0, 0, 0));
        add_row(make_imm(OP_ADDUI, 11, rand8()));
    endtask

    task automatic check_writeback();
        reg_addr_t e_addr;
        word_t     e_val;
        n_wb++;
        if (exp_addr_q.size() == 0) begin
            errors++;
            $display("Extra write-back to r%0d at time %0t", wb.addr, $time);
        end else begin
            e_addr = exp_addr_q.pop_front();
            e_val  = exp_val_q.pop_front();
            if (wb.addr != e_addr || wb.data != e_val) begin
                errors++;
                $display("FAIL %0t: write-back r%0d = %h, expected r%0d = %h",
                         $time, wb.addr, wb.data, e_addr, e_val);
            end
            // Fetch is the cycle before the pc change
            if (cycle - last_pc_change != 2) begin
                errors++;
                $display("FAIL %0t: write-back in cycle %0d of its instruction, expected 4",
                         $time, cycle - last_pc_change + 2);
            end
        end
    endtask

    always @(negedge clk) begin
        instr <= instr_t'(imem[pc[8:1]]);
    end

    always @(negedge clk) begin
        word_t e_pc;
        cycle = cycle + 1;
        if (rst) begin
            if (pc != pc_prev) begin
                last_pc_change = cycle;
                if (exp_pc_q.size() != 0) begin
                    e_pc = exp_pc_q.pop_front();
                    if (pc != e_pc) begin
                        errors++;
                        $display("FAIL %0t: pc moved to %h, expected %h", $time, pc, e_pc);
                    end
                end
            end
            if (wb.valid) begin
                check_writeback();
            end
        end
        pc_prev = pc;
    end

    initial begin
        int i;
        rst = 1'b0;
        build_program();
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {4'h1, 12'(i)};  // No-op fill
        end
        for (i = 0; i < n_rows; i++) begin
            imem[i] = row_instr[i];
            if (row_class[i] != CL_SKIP) begin
                exp_pc_q.push_back(word_t'(2 * i + `CPU_PC_STEP));
            end
            if (row_class[i] == CL_WRITE) begin
                exp_addr_q.push_back(row_addr[i]);
                exp_val_q.push_back(row_val[i]);
            end
            if (row_taken[i]) begin
                exp_pc_q.push_back(row_target[i]);
            end
        end
        built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        while (exp_addr_q.size() != 0 || exp_pc_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);  // Catch stray write-backs
        $display("Errors: %0d, write-backs seen: %0d", errors, n_wb);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (built);
        #((RESET_CYCLES + n_rows * 4 * 2) * CLK_PERIOD);
        $display("Timeout with %0d write-backs and %0d pc changes still missing",
                 exp_addr_q.size(), exp_pc_q.size());
        $display("Errors: %0d, write-backs seen: %0d", errors, n_wb);
        $display("Checks failed");
        $finish;
    end

endmodule
